//--- sim.f
egress_pkg.sv
egress_port_lane.sv
egress_port_group.sv
egress_input_ctrl.sv
mpls_egress.sv
tb_mpls_egress.sv

//--- Makefile
# Verilator build and run for the MPLS egress distributor

VERILATOR ?= verilator
TOP       ?= tb_mpls_egress
RTL_TOP   ?= mpls_egress
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) egress_pkg.sv egress_port_lane.sv egress_port_group.sv \
		egress_input_ctrl.sv mpls_egress.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mpls_egress.sv
`default_nettype none
////////////////////////////////////////////////////////////
// Directed testbench for the MPLS egress distributor, with a
// per-port golden byte model checked on every output beat
////////////////////////////////////////////////////////////

module tb_mpls_egress;
    timeunit 1ns;
    timeprecision 1ps;

    import egress_pkg::*;

    localparam int N8 = 3;
    localparam int N32 = 3;
    localparam int NUM_PORTS = N8 + N32;
    // Worst case of five words per packet in tests 4 and 5
    localparam int TOTAL_WORDS = 24 + 7 + 20 * 5 + 30 * 5;
    localparam int MAX_CYCLES = 20 * TOTAL_WORDS;

    logic clk_ifc;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    egress_word_t in_data;
    egr_keep_t in_keep;
    logic in_last;
    port_idx_t in_port;
    logic [N8-1:0] p8_valid;
    logic [N8*BYTES_8B*8-1:0] p8_data;
    logic [N8-1:0] p8_last;
    logic [N8-1:0] p8_ready;
    logic [N32-1:0] p32_valid;
    logic [N32*BYTES_32B*8-1:0] p32_data;
    logic [N32*BYTES_32B-1:0] p32_keep;
    logic [N32-1:0] p32_last;
    logic [N32-1:0] p32_ready;
    logic bad_port_seen;
    drop_count_t drop_count;

    integer seed;
    int cycle_count;
    logic rand_ready;
    egr_byte_t next_byte;
    egr_byte_t exp_bytes [NUM_PORTS][$];
    logic exp_last [NUM_PORTS][$];
    int pkt_sent [NUM_PORTS];
    int pkt_seen [NUM_PORTS];

    mpls_egress #(
        .NUM_8B_PORTS  (N8),
        .NUM_32B_PORTS (N32),
        .BUF_WORDS     (4)
    ) dut (
        .clk_ifc       (clk_ifc),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_keep       (in_keep),
        .in_last       (in_last),
        .in_port       (in_port),
        .p8_valid      (p8_valid),
        .p8_data       (p8_data),
        .p8_last       (p8_last),
        .p8_ready      (p8_ready),
        .p32_valid     (p32_valid),
        .p32_data      (p32_data),
        .p32_keep      (p32_keep),
        .p32_last      (p32_last),
        .p32_ready     (p32_ready),
        .bad_port_seen (bad_port_seen),
        .drop_count    (drop_count)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #10 clk_ifc = ~clk_ifc;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_byte(string name, egr_byte_t got, egr_byte_t exp);
        if (got !== exp) abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(string name, drop_count_t got, drop_count_t exp);
        if (got !== exp) abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitors, evaluated at the falling edge where the
    // beat and its ready are both stable until the next rise

    task automatic beat_8b(int p);
        egr_byte_t b;
        logic l;
        if (exp_bytes[p].size() == 0) abort_run($sformatf("unexpected beat on port %0d", p));
        b = exp_bytes[p].pop_front();
        l = exp_last[p].pop_front();
        check_byte($sformatf("p8_data[%0d]", p), p8_data[p*8 +: 8], b);
        check_flag($sformatf("p8_last[%0d]", p), p8_last[p], l);
        if (p8_last[p]) pkt_seen[p]++;
    endtask

    // A 32-bit beat carries up to four bytes, fewer at packet end
    task automatic beat_32b(int i);
        int p;
        int n;
        logic done;
        egr_byte_t b;
        p = N8 + i;
        n = 0;
        done = 1'b0;
        while (n < 4 && !done) begin
            if (exp_bytes[p].size() == 0) abort_run($sformatf("unexpected beat on port %0d", p));
            b = exp_bytes[p].pop_front();
            done = exp_last[p].pop_front();
            check_byte($sformatf("p32_data[%0d] byte %0d", i, n), p32_data[i*32 + n*8 +: 8], b);
            n++;
        end
        for (int k = 0; k < 4; k++) begin
            check_flag($sformatf("p32_keep[%0d] bit %0d", i, k), p32_keep[i*4 + k], k < n);
        end
        check_flag($sformatf("p32_last[%0d]", i), p32_last[i], done);
        if (p32_last[i]) pkt_seen[p]++;
    endtask

    initial begin
        forever begin
            @(negedge clk_ifc);
            if (rand_ready) begin
                p8_ready = 3'($random(seed));
                p32_ready = 3'($random(seed));
            end else begin
                p8_ready = '1;
                p32_ready = '1;
            end
            for (int i = 0; i < N8; i++) begin
                if (p8_valid[i] && p8_ready[i]) beat_8b(i);
            end
            for (int i = 0; i < N32; i++) begin
                if (p32_valid[i] && p32_ready[i]) beat_32b(i);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_ifc);
            cycle_count++;
        end
        $display("timeout: the run did not complete within %0d cycles", MAX_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Golden queues are filled as each word is built
    task automatic send_packet(port_idx_t port, int len);
        egress_word_t word;
        egr_keep_t keep;
        int n_words;
        int idx;
        n_words = (len + 7) / 8;
        for (int w = 0; w < n_words; w++) begin
            word = '0;
            keep = '0;
            for (int b = 0; b < EGR_DATA_BYTES; b++) begin
                idx = w * 8 + b;
                if (idx < len) begin
                    word.bytes[b] = next_byte;
                    keep[b] = 1'b1;
                    if (int'(port) < NUM_PORTS) begin
                        exp_bytes[port].push_back(next_byte);
                        exp_last[port].push_back(idx == len - 1);
                    end
                    next_byte++;
                end
            end
            @(negedge clk_ifc);
            in_valid = 1'b1;
            in_data = word;
            in_keep = keep;
            in_last = (w == n_words - 1);
            in_port = port;
            #1;
            while (!in_ready) begin
                @(negedge clk_ifc);
                #1;
            end
        end
        if (int'(port) < NUM_PORTS) pkt_sent[port]++;
        @(negedge clk_ifc);
        in_valid = 1'b0;
        in_last = 1'b0;
        in_keep = '0;
    endtask

    // The DUT is drained once no port offers a beat
    task automatic wait_drain();
        while (|p8_valid || |p32_valid) @(negedge clk_ifc);
        repeat (2) @(posedge clk_ifc);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests

    task automatic test_reset_state();
        @(negedge clk_ifc);
        for (int i = 0; i < N8; i++) begin
            check_flag($sformatf("p8_valid[%0d]", i), p8_valid[i], 1'b0);
        end
        for (int i = 0; i < N32; i++) begin
            check_flag($sformatf("p32_valid[%0d]", i), p32_valid[i], 1'b0);
        end
        check_flag("bad_port_seen", bad_port_seen, 1'b0);
        check_count("drop_count", drop_count, '0);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    task automatic test_routing();
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_packet(port_idx_t'(p), 16);
            send_packet(port_idx_t'(p), 13);
        end
        wait_drain();
    endtask

    task automatic test_bad_port();
        send_packet(port_idx_t'(6), 20);
        send_packet(port_idx_t'(7), 9);
        check_flag("bad_port_seen", bad_port_seen, 1'b1);
        check_count("drop_count", drop_count, 16'd2);
        send_packet(port_idx_t'(2), 16);
        wait_drain();
        @(negedge clk_ifc);
        check_flag("bad_port_seen", bad_port_seen, 1'b1);
        check_count("drop_count", drop_count, 16'd2);
    endtask

    task automatic test_backpressure();
        int lens [20];
        port_idx_t ports [20];
        for (int k = 0; k < 20; k++) begin
            lens[k] = int'($unsigned($random(seed)) % 40) + 1;
            ports[k] = port_idx_t'($unsigned($random(seed)) % NUM_PORTS);
        end
        @(posedge clk_ifc);
        rand_ready = 1'b1;
        for (int k = 0; k < 20; k++) send_packet(ports[k], lens[k]);
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic test_random_lengths();
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkt_sent[p] = 0;
            pkt_seen[p] = 0;
        end
        for (int k = 0; k < 30; k++) begin
            send_packet(port_idx_t'($unsigned($random(seed)) % NUM_PORTS),
                        int'($unsigned($random(seed)) % 40) + 1);
        end
        wait_drain();
        @(negedge clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_flag($sformatf("queue %0d empty", p), exp_bytes[p].size() == 0, 1'b1);
            check_count($sformatf("packets on port %0d", p),
                        drop_count_t'(pkt_seen[p]), drop_count_t'(pkt_sent[p]));
        end
    endtask

    initial begin
        seed = 81180;
        rand_ready = 1'b0;
        next_byte = '0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_port = '0;
        p8_ready = '1;
        p32_ready = '1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pkt_sent[p] = 0;
            pkt_seen[p] = 0;
        end
        repeat (4) @(negedge clk_ifc);
        rst_n = 1'b1;

        test_reset_state();
        test_routing();
        test_bad_port();
        test_backpressure();
        test_random_lengths();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mpls_egress.sv
`default_nettype none
////////////////////////////////////////////////////////////
// MPLS egress distributor top: steers a 64-bit packet stream
// to 8-bit and 32-bit physical ports by port number
////////////////////////////////////////////////////////////

module mpls_egress #(
    parameter int NUM_8B_PORTS  = 3,
    parameter int NUM_32B_PORTS = 3,
    parameter int BUF_WORDS     = 4
) (
    input  wire logic                                           clk_ifc,
    input  wire logic                                           rst_n,

    // Input stream
    input  wire logic                                           in_valid,
    output logic                                                in_ready,
    input  wire egress_pkg::egress_word_t                       in_data,
    input  wire egress_pkg::egr_keep_t                          in_keep,
    input  wire logic                                           in_last,
    input  wire egress_pkg::port_idx_t                          in_port,

    // 8-bit ports
    output logic [NUM_8B_PORTS-1:0]                             p8_valid,
    output logic [NUM_8B_PORTS*egress_pkg::BYTES_8B*8-1:0]      p8_data,
    output logic [NUM_8B_PORTS-1:0]                             p8_last,
    input  wire logic [NUM_8B_PORTS-1:0]                        p8_ready,

    // 32-bit ports
    output logic [NUM_32B_PORTS-1:0]                            p32_valid,
    output logic [NUM_32B_PORTS*egress_pkg::BYTES_32B*8-1:0]    p32_data,
    output logic [NUM_32B_PORTS*egress_pkg::BYTES_32B-1:0]      p32_keep,
    output logic [NUM_32B_PORTS-1:0]                            p32_last,
    input  wire logic [NUM_32B_PORTS-1:0]                       p32_ready,

    // Status
    output logic                                                bad_port_seen,
    output egress_pkg::drop_count_t                             drop_count
);

    import egress_pkg::*;

    logic take;
    logic claim_8b;
    logic room_8b;
    logic claim_32b;
    logic room_32b;

    egress_input_ctrl u_ctrl (
        .clk_ifc       (clk_ifc),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .claim_8b      (claim_8b),
        .room_8b       (room_8b),
        .claim_32b     (claim_32b),
        .room_32b      (room_32b),
        .in_ready      (in_ready),
        .take          (take),
        .bad_port_seen (bad_port_seen),
        .drop_count    (drop_count)
    );

    ////////////////////////////////////////////////////////////
    // Port groups, numbered 8-bit first then 32-bit

    // Single-byte beats always carry their byte, keep stays open
    egress_port_group #(
        .FIRST_PORT (0),
        .NUM_PORTS  (NUM_8B_PORTS),
        .PORT_BYTES (BYTES_8B),
        .BUF_WORDS  (BUF_WORDS)
    ) u_group_8b (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .take      (take),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_port   (in_port),
        .out_ready (p8_ready),
        .claim     (claim_8b),
        .room      (room_8b),
        .out_valid (p8_valid),
        .out_data  (p8_data),
        .out_keep  (),
        .out_last  (p8_last)
    );

    egress_port_group #(
        .FIRST_PORT (NUM_8B_PORTS),
        .NUM_PORTS  (NUM_32B_PORTS),
        .PORT_BYTES (BYTES_32B),
        .BUF_WORDS  (BUF_WORDS)
    ) u_group_32b (
        .clk_ifc   (clk_ifc),
        .rst_n     (rst_n),
        .take      (take),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_port   (in_port),
        .out_ready (p32_ready),
        .claim     (claim_32b),
        .room      (room_32b),
        .out_valid (p32_valid),
        .out_data  (p32_data),
        .out_keep  (p32_keep),
        .out_last  (p32_last)
    );

endmodule

`default_nettype wire

//--- egress_input_ctrl.sv
`default_nettype none
////////////////////////////////////////////////////////////
// Input flow control: merges group claims into ready and
// take, and discards packets for unowned port numbers
////////////////////////////////////////////////////////////

module egress_input_ctrl (
    input  wire logic                 clk_ifc,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire logic                 in_last,
    input  wire logic                 claim_8b,
    input  wire logic                 room_8b,
    input  wire logic                 claim_32b,
    input  wire logic                 room_32b,
    output logic                      in_ready,
    output logic                      take,
    output logic                      bad_port_seen,
    output egress_pkg::drop_count_t   drop_count
);

    import egress_pkg::*;

    logic first_word;
    logic dropping;
    logic claimed;
    logic drop_word;
    logic xfer;

    assign claimed = claim_8b || claim_32b;

    // A packet is discarded when nobody owns its first word
    assign drop_word = dropping || (first_word && !claimed);

    // Dropped words flow at full rate, others wait for room
    assign in_ready = drop_word
                   || (claim_8b && room_8b)
                   || (claim_32b && room_32b);

    assign xfer = in_valid && in_ready;
    assign take = xfer && !drop_word;

    ////////////////////////////////////////////////////////////
    // Packet boundary and drop state

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            first_word <= 1'b1;
            dropping   <= 1'b0;
        end else if (xfer) begin
            first_word <= in_last;
            if (in_last) begin
                dropping <= 1'b0;
            end else if (drop_word) begin
                dropping <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Status, counted once per dropped packet at its last word

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            bad_port_seen <= 1'b0;
            drop_count    <= '0;
        end else if (xfer && drop_word && in_last) begin
            bad_port_seen <= 1'b1;
            if (drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Group ranges must not overlap
    a_one_owner: assert property (
        @(posedge clk_ifc) disable iff (!rst_n) !(claim_8b && claim_32b)
    );

endmodule

`default_nettype wire

//--- egress_port_group.sv
`default_nettype none
////////////////////////////////////////////////////////////
// A set of same-width egress lanes covering a contiguous
// range of port numbers; claims words and reports room
////////////////////////////////////////////////////////////

module egress_port_group #(
    parameter int FIRST_PORT = 0,
    parameter int NUM_PORTS  = 3,
    parameter int PORT_BYTES = 1,
    parameter int BUF_WORDS  = 4
) (
    input  wire logic                            clk_ifc,
    input  wire logic                            rst_n,
    input  wire logic                            take,
    input  wire egress_pkg::egress_word_t        in_data,
    input  wire egress_pkg::egr_keep_t           in_keep,
    input  wire logic                            in_last,
    input  wire egress_pkg::port_idx_t           in_port,
    input  wire logic [NUM_PORTS-1:0]            out_ready,
    output logic                                 claim,
    output logic                                 room,
    output logic [NUM_PORTS-1:0]                 out_valid,
    output logic [NUM_PORTS*PORT_BYTES*8-1:0]    out_data,
    output logic [NUM_PORTS*PORT_BYTES-1:0]      out_keep,
    output logic [NUM_PORTS-1:0]                 out_last
);

    import egress_pkg::*;

    localparam int OFF_W = PORT_IDX_W + 1;

    // Port number relative to the first port of the group; the
    // extra bit keeps numbers below the range out of it
    logic [OFF_W-1:0]     port_off;
    logic [NUM_PORTS-1:0] lane_hit;
    logic [NUM_PORTS-1:0] lane_full;

    assign port_off = {1'b0, in_port} - OFF_W'(FIRST_PORT);
    assign claim    = (port_off < OFF_W'(NUM_PORTS));

    // Room comes only from the lane that is addressed
    assign room = |(lane_hit & ~lane_full);

    ////////////////////////////////////////////////////////////
    // Lanes

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
        logic lane_push;

        assign lane_hit[i] = (port_off == OFF_W'(i));
        assign lane_push   = take && lane_hit[i];

        egress_port_lane #(
            .BUF_WORDS  (BUF_WORDS),
            .PORT_BYTES (PORT_BYTES)
        ) u_lane (
            .clk_ifc   (clk_ifc),
            .rst_n     (rst_n),
            .push      (lane_push),
            .push_data (in_data),
            .push_keep (in_keep),
            .push_last (in_last),
            .out_ready (out_ready[i]),
            .full      (lane_full[i]),
            .out_valid (out_valid[i]),
            .out_data  (out_data[i*PORT_BYTES*8 +: PORT_BYTES*8]),
            .out_keep  (out_keep[i*PORT_BYTES +: PORT_BYTES]),
            .out_last  (out_last[i])
        );
    end

endmodule

`default_nettype wire

//--- egress_port_lane.sv
`default_nettype none
////////////////////////////////////////////////////////////
// One physical egress port: a circular word buffer followed
// by a downsizer that emits PORT_BYTES-wide beats
////////////////////////////////////////////////////////////

module egress_port_lane #(
    parameter int BUF_WORDS  = 4,
    parameter int PORT_BYTES = 1
) (
    input  wire logic                      clk_ifc,
    input  wire logic                      rst_n,
    input  wire logic                      push,
    input  wire egress_pkg::egress_word_t  push_data,
    input  wire egress_pkg::egr_keep_t     push_keep,
    input  wire logic                      push_last,
    input  wire logic                      out_ready,
    output logic                           full,
    output logic                           out_valid,
    output logic [PORT_BYTES*8-1:0]        out_data,
    output logic [PORT_BYTES-1:0]          out_keep,
    output logic                           out_last
);

    import egress_pkg::*;

    localparam int BEATS  = EGR_DATA_BYTES / PORT_BYTES;
    localparam int BEAT_W = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int PTR_W  = (BUF_WORDS > 1) ? $clog2(BUF_WORDS) : 1;
    localparam int CNT_W  = $clog2(BUF_WORDS + 1);

    localparam logic [PTR_W-1:0]  LAST_PTR  = PTR_W'(BUF_WORDS - 1);
    localparam logic [CNT_W-1:0]  FULL_CNT  = CNT_W'(BUF_WORDS);

    ////////////////////////////////////////////////////////////
    // Word buffer

    egress_word_t mem_data [BUF_WORDS];
    egr_keep_t    mem_keep [BUF_WORDS];
    logic         mem_last [BUF_WORDS];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [BEAT_W-1:0] beat_idx;

    egress_word_t      head_word;
    egr_keep_t         head_keep;
    logic              head_last;
    logic [BEATS-1:0]  beat_more;
    logic              word_done;
    logic              beat_fire;
    logic              pop;

    always_ff @(posedge clk_ifc) begin
        if (push) begin
            mem_data[wr_ptr] <= push_data;
            mem_keep[wr_ptr] <= push_keep;
            mem_last[wr_ptr] <= push_last;
        end
    end

    assign head_word = mem_data[rd_ptr];
    assign head_keep = mem_keep[rd_ptr];
    assign head_last = mem_last[rd_ptr];

    assign full = (count == FULL_CNT);

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Downsizer

    // Keep is contiguous, so a later beat holds data only if its
    // lowest byte is valid
    for (genvar b = 0; b < BEATS; b++) begin : g_more
        if (b < BEATS - 1) begin : g_mid
            assign beat_more[b] = |head_keep[(b+1)*PORT_BYTES +: PORT_BYTES];
        end else begin : g_end
            assign beat_more[b] = 1'b0;
        end
    end

    assign word_done = !beat_more[beat_idx];
    assign out_valid = (count != '0);
    assign beat_fire = out_valid && out_ready;
    assign pop       = beat_fire && word_done;

    always_ff @(posedge clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (beat_fire) begin
            beat_idx <= word_done ? '0 : beat_idx + 1'b1;
        end
    end

    // Pick the union view that matches the port width
    if (PORT_BYTES == 1) begin : g_byte_view
        assign out_data = head_word.bytes[beat_idx];
    end else if (PORT_BYTES == 4) begin : g_dword_view
        assign out_data = head_word.dwords[beat_idx];
    end else begin : g_raw_view
        assign out_data = head_word[beat_idx*PORT_BYTES*8 +: PORT_BYTES*8];
    end

    assign out_keep = head_keep[beat_idx*PORT_BYTES +: PORT_BYTES];
    assign out_last = head_last && word_done;

    ////////////////////////////////////////////////////////////
    // Checks

    // The input controller must hold off a word for a full lane
    a_no_push_full: assert property (
        @(posedge clk_ifc) disable iff (!rst_n) push |-> !full
    );

    // A packet's closing word carries at least one byte
    a_last_keep: assert property (
        @(posedge clk_ifc) disable iff (!rst_n) (push && push_last) |-> (push_keep != '0)
    );

endmodule

`default_nettype wire

//--- egress_pkg.sv
`default_nettype none
////////////////////////////////////////////////////////////
// Widths and types shared by the egress distributor and its
// testbench; import into a module body or use scoped names
////////////////////////////////////////////////////////////

package egress_pkg;

    ////////////////////////////////////////////////////////////
    // Input stream geometry

    // Bytes carried by one input word
    localparam int EGR_DATA_BYTES = 8;

    // Global port number width, enough for 8 port numbers
    localparam int PORT_IDX_W = 3;

    ////////////////////////////////////////////////////////////
    // Physical port widths in bytes

    localparam int BYTES_8B  = 1;
    localparam int BYTES_32B = 4;

    ////////////////////////////////////////////////////////////
    // Types

    typedef logic [PORT_IDX_W-1:0]     port_idx_t;
    typedef logic [EGR_DATA_BYTES-1:0] egr_keep_t;
    typedef logic [7:0]                egr_byte_t;

    // One input word, read as bytes by the 8-bit lanes and as
    // dwords by the 32-bit lanes; index 0 sits in the low bits
    // and leaves the port first
    typedef union packed {
        egr_byte_t [EGR_DATA_BYTES-1:0] bytes;
        logic [1:0][31:0]               dwords;
    } egress_word_t;

    // Dropped packet count, saturates at all ones
    typedef logic [15:0] drop_count_t;

endpackage

`default_nettype wire
